// ==== sdramPkg.sv ====
//==========================================================================
// SDRAM device view shared by the controller blocks
// Widths of the 16-bit part, command encodings, fixed timing and the
// address word that is read either flat or as bank, row and column
//==========================================================================
`default_nettype none

package sdramPkg;

    // Device geometry
    localparam int dataW = 16;                 // DQ width
    localparam int bankW = 2;
    localparam int rowW  = 12;                 // Also width of the SA pins
    localparam int colW  = 8;                  // 256 words per page
    localparam int addrW = bankW + rowW + colW; // Linear word address, 22

    // Fixed timing in CLK cycles
    localparam int tRcd       = 2;             // ACTIVE to READ or WRITE
    localparam int casLatency = 3;             // READ to first data

    // {rasN, casN, weN}
    typedef enum logic [2:0] {
        NOP        = 3'b111,
        ACTIVE     = 3'b011,
        READ       = 3'b101,
        WRITE      = 3'b100,
        BURST_STOP = 3'b110,
        PRECHARGE  = 3'b010
    } sdramCmdE;

    typedef struct packed {
        logic [bankW-1:0] bank;                // Top bits of the word
        logic [rowW-1:0]  row;
        logic [colW-1:0]  col;                 // Bottom bits, page offset
    } sdramLocT;

    // Same 22 bits, flat for stepping, split for the command pins
    typedef union packed {
        logic [addrW-1:0] word;
        sdramLocT         loc;
    } sdramAddrU;

    // Everything the controller drives towards the chip, CKE excluded
    typedef struct packed {
        logic             csN;
        sdramCmdE         cmd;
        logic [bankW-1:0] ba;
        logic [rowW-1:0]  sa;
        logic [1:0]       dqm;                 // One bit per byte lane
        logic             dqOe;                // Testbench resolves DQ
    } sdramBusT;

endpackage

`default_nettype wire

// ==== portPkg.sv ====
//==========================================================================
// Port-side definitions
// Per-port ring configuration and the burst request that the arbiter
// hands to the sequencer
//==========================================================================
`default_nettype none

package portPkg;

    localparam int lengthW   = 6;              // Burst 1..32, 0 disables
    localparam int fifoDepth = 64;             // Words per port FIFO
    localparam int levelW    = 7;              // Fill level 0..64

    // Ring bounds and step, one per port
    typedef struct packed {
        logic [sdramPkg::addrW-1:0] startAddr;
        logic [sdramPkg::addrW-1:0] maxAddr;
        logic [lengthW-1:0]         length;
    } portCfgT;

    typedef struct packed {
        sdramPkg::sdramAddrU addr;             // First word of the burst
        logic [lengthW-1:0]  length;
        logic                isWrite;          // 0 means read burst
    } burstReqT;

endpackage

`default_nettype wire

// ==== burstFifo.sv ====
//==========================================================================
// Synchronous show-ahead FIFO of 64 words
// Head word is valid whenever level is non-zero; clear empties it
// Used as write FIFO and as read FIFO of the controller
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module burstFifo (
    input  wire logic                        CLK,
    input  wire logic                        RESET_N,
    input  wire logic                        clear,     // Sync flush
    input  wire logic                        push,
    input  wire logic [sdramPkg::dataW-1:0]  pushData,
    input  wire logic                        pop,
    output logic      [sdramPkg::dataW-1:0]  headData,  // Show-ahead
    output logic      [portPkg::levelW-1:0]  level
);
    import sdramPkg::*;
    import portPkg::*;

    logic [dataW-1:0]  mem [fifoDepth];
    logic [levelW-2:0] wrPtr;                  // Wraps at fifoDepth
    logic [levelW-2:0] rdPtr;

    assign headData = mem[rdPtr];

    // Storage
    always_ff @(posedge CLK)
    begin
        if (push && !clear)
            mem[wrPtr] <= pushData;
    end

    // Pointers and fill level
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end
        else if (clear)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;                       // Pending push is dropped
        end
        else
        begin
            if (push)
                wrPtr <= wrPtr + 1'b1;
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            if (push && !pop)
                level <= level + 1'b1;
            else if (pop && !push)
                level <= level - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== portAddressRing.sv ====
//==========================================================================
// Burst address ring of one port
// Steps by the burst length after each burst and returns to the start
// address once the next burst would pass maxAddr
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module portAddressRing (
    input  wire logic                 CLK,
    input  wire logic                 RESET_N,
    input  wire portPkg::portCfgT     cfg,
    input  wire logic                 reload,      // Back to start
    input  wire logic                 advance,     // Burst finished
    output sdramPkg::sdramAddrU       burstAddr
);
    import sdramPkg::*;

    logic [addrW-1:0] stepLen;
    logic [addrW-1:0] wrapLimit;               // Last start that still steps
    logic [addrW-1:0] nextAddr;

    assign stepLen   = addrW'(cfg.length);
    assign wrapLimit = cfg.maxAddr - stepLen;
    assign nextAddr  = (burstAddr.word < wrapLimit) ? burstAddr.word + stepLen
                                                    : cfg.startAddr;

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
            burstAddr.word <= cfg.startAddr;   // Config is stable in reset
        else if (reload)
            burstAddr.word <= cfg.startAddr;   // Reload wins over advance
        else if (advance)
            burstAddr.word <= nextAddr;
    end

endmodule

`default_nettype wire

// ==== burstArbiter.sv ====
//==========================================================================
// Burst arbiter for the write and read port
// Write goes first once a full burst is buffered, else read while the
// read FIFO is short of one burst. One request in flight at a time,
// with an idle cycle after every burstDone
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module burstArbiter (
    input  wire logic                         CLK,
    input  wire logic                         RESET_N,
    input  wire portPkg::portCfgT             writeCfg,
    input  wire portPkg::portCfgT             readCfg,
    input  wire sdramPkg::sdramAddrU          writeAddr,   // Ring heads
    input  wire sdramPkg::sdramAddrU          readAddr,
    input  wire logic [portPkg::levelW-1:0]   writeLevel,
    input  wire logic [portPkg::levelW-1:0]   readLevel,
    input  wire logic                         anyClear,    // Hold off starts
    input  wire logic                         burstDone,
    output logic                              burstStart,  // One-cycle pulse
    output portPkg::burstReqT                 burstReq     // Held to done
);
    import portPkg::*;

    logic busy;                                // Start issued, no done yet
    logic writeReady;
    logic readReady;
    logic launch;

    //======================================================================
    // Qualification
    //======================================================================
    assign writeReady = (writeCfg.length != '0) &&
                        (writeLevel >= levelW'(writeCfg.length));
    assign readReady  = readLevel < levelW'(readCfg.length); // 0 never
    assign launch     = !busy && !anyClear && (writeReady || readReady);

    //======================================================================
    // Start pulse and busy flag
    //======================================================================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            burstStart <= 1'b0;
            busy       <= 1'b0;
        end
        else
        begin
            burstStart <= launch;
            if (launch)
                busy <= 1'b1;
            else if (burstDone)
                busy <= 1'b0;                  // Next look one cycle later
        end
    end

    // Request captured with the start
    always_ff @(posedge CLK)
    begin
        if (launch)
        begin
            if (writeReady)
            begin
                burstReq.addr    <= writeAddr;
                burstReq.length  <= writeCfg.length;
                burstReq.isWrite <= 1'b1;
            end
            else
            begin
                burstReq.addr    <= readAddr;
                burstReq.length  <= readCfg.length;
                burstReq.isWrite <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sdramSequencer.sv ====
//==========================================================================
// Fixed-timing burst sequencer
// ACTIVE, page-mode READ or WRITE, BURST STOP and PRECHARGE at cycles
// counted from burstStart, plus DQM, DQ enable and the FIFO strobes
// Every output comes straight from a register
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module sdramSequencer (
    input  wire logic               CLK,
    input  wire logic               RESET_N,
    input  wire logic               burstStart,
    input  wire portPkg::burstReqT  burstReq,
    output logic                    burstDone,    // One-cycle pulse
    output logic                    writePop,     // Write FIFO head consumed
    output logic                    readPush,     // dqIn into read FIFO
    output sdramPkg::sdramBusT      sdramBus
);
    import sdramPkg::*;
    import portPkg::*;

    typedef logic [lengthW:0] cntT;            // Holds up to 39

    burstReqT reqQ;                            // Latched request
    logic     busy;
    cntT      cycleCnt;                        // Cycle now on the pins
    cntT      nextCnt;                         // Cycle being prepared
    cntT      len;

    // Cycle markers of the running burst
    cntT rwCycle;
    cntT wrLast;
    cntT stopCycle;
    cntT preCycle;
    cntT rdFirst;
    cntT rdLast;
    cntT doneCycle;

    sdramBusT busNext;
    logic     popNext;
    logic     pushNext;
    logic     doneNext;

    assign len       = cntT'(reqQ.length);
    assign nextCnt   = cycleCnt + 1'b1;
    assign rwCycle   = cntT'(tRcd);
    assign wrLast    = rwCycle + len - 1'b1;
    assign stopCycle = rwCycle + len;          // Same cycle for both directions
    assign preCycle  = stopCycle + 2'd2;
    assign rdFirst   = cntT'(tRcd + casLatency);
    assign rdLast    = rdFirst + len - 1'b1;
    assign doneCycle = rdFirst + len + 2'd2;

    //======================================================================
    // Next pin state
    //======================================================================
    always_comb
    begin
        busNext  = '{csN: 1'b1, cmd: NOP, ba: '0, sa: '0, dqm: 2'b11, dqOe: 1'b0};
        popNext  = 1'b0;
        pushNext = 1'b0;
        doneNext = 1'b0;
        if (burstStart)
        begin
            busNext.csN = 1'b0;                // Cycle 0, open the row
            busNext.cmd = ACTIVE;
            busNext.ba  = burstReq.addr.loc.bank;
            busNext.sa  = burstReq.addr.loc.row;
        end
        else if (busy)
        begin
            busNext.csN = 1'b0;
            busNext.ba  = reqQ.addr.loc.bank;
            if (nextCnt == rwCycle)
            begin
                busNext.cmd = reqQ.isWrite ? WRITE : READ;
                busNext.sa  = rowW'(reqQ.addr.loc.col); // A10 low, no auto precharge
            end
            else if (nextCnt == stopCycle)
            begin
                busNext.cmd = BURST_STOP;      // Ends the full-page burst
            end
            else if (nextCnt == preCycle)
            begin
                busNext.cmd = PRECHARGE;       // A10 low, this bank only
            end
            popNext  = reqQ.isWrite && (nextCnt >= rwCycle) && (nextCnt <= wrLast);
            pushNext = !reqQ.isWrite && (nextCnt >= rdFirst) && (nextCnt <= rdLast);
            busNext.dqOe = popNext;
            busNext.dqm  = (popNext || pushNext) ? 2'b00 : 2'b11;
            doneNext     = (nextCnt == doneCycle);
        end
    end

    //======================================================================
    // Registers
    //======================================================================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            busy      <= 1'b0;
            cycleCnt  <= '0;
            sdramBus  <= '{csN: 1'b1, cmd: NOP, ba: '0, sa: '0, dqm: 2'b11, dqOe: 1'b0};
            writePop  <= 1'b0;
            readPush  <= 1'b0;
            burstDone <= 1'b0;
        end
        else
        begin
            if (burstStart)
                busy <= 1'b1;
            else if (doneNext)
                busy <= 1'b0;                  // Done cycle is the last one
            if (burstStart)
                cycleCnt <= '0;
            else if (busy)
                cycleCnt <= nextCnt;
            sdramBus  <= busNext;
            writePop  <= popNext;
            readPush  <= pushNext;
            burstDone <= doneNext;
        end
    end

    // Request copy for the rest of the burst
    always_ff @(posedge CLK)
    begin
        if (burstStart)
            reqQ <= burstReq;
    end

endmodule

`default_nettype wire

// ==== sdramMultiPort.sv ====
//==========================================================================
// Two-port burst SDRAM controller, top level
// One write and one read port, each with a 64-word FIFO and an address
// ring, sharing a single 16-bit SDRAM through the arbiter and sequencer
// DQ is split into dqOut, dqIn and sdramBus.dqOe for the board or bench
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module sdramMultiPort (
    input  wire logic                         CLK,
    input  wire logic                         RESET_N,
    input  wire portPkg::portCfgT             writeCfg,
    input  wire portPkg::portCfgT             readCfg,
    input  wire logic [sdramPkg::dataW-1:0]   writeData,
    input  wire logic                         writeEn,
    input  wire logic                         writeClear,  // Also reloads ring
    input  wire logic                         readEn,
    input  wire logic                         readClear,   // Also reloads ring
    output logic      [sdramPkg::dataW-1:0]   readData,    // Show-ahead
    output logic      [portPkg::levelW-1:0]   writeLevel,
    output logic      [portPkg::levelW-1:0]   readLevel,
    output sdramPkg::sdramBusT                sdramBus,
    output logic      [sdramPkg::dataW-1:0]   dqOut,
    input  wire logic [sdramPkg::dataW-1:0]   dqIn
);
    import sdramPkg::*;
    import portPkg::*;

    sdramAddrU writeAddr;
    sdramAddrU readAddr;
    burstReqT  burstReq;
    logic      burstStart;
    logic      burstDone;
    logic      writePop;
    logic      readPush;

    //======================================================================
    // Port FIFOs
    //======================================================================
    burstFifo writeFifo (
        .CLK(CLK), .RESET_N(RESET_N),
        .clear(writeClear), .push(writeEn), .pushData(writeData),
        .pop(writePop), .headData(dqOut), // Head drives DQ directly
        .level(writeLevel)
    );

    burstFifo readFifo (
        .CLK(CLK), .RESET_N(RESET_N),
        .clear(readClear), .push(readPush), .pushData(dqIn),
        .pop(readEn), .headData(readData), .level(readLevel)
    );

    //======================================================================
    // Address rings, stepped by the burst that just finished
    //======================================================================
    portAddressRing writeRing (
        .CLK(CLK), .RESET_N(RESET_N), .cfg(writeCfg), .reload(writeClear),
        .advance(burstDone && burstReq.isWrite), .burstAddr(writeAddr)
    );

    portAddressRing readRing (
        .CLK(CLK), .RESET_N(RESET_N), .cfg(readCfg), .reload(readClear),
        .advance(burstDone && !burstReq.isWrite), .burstAddr(readAddr)
    );

    //======================================================================
    // Arbiter and sequencer
    //======================================================================
    burstArbiter arbiter (
        .CLK(CLK), .RESET_N(RESET_N),
        .writeCfg(writeCfg), .readCfg(readCfg),
        .writeAddr(writeAddr), .readAddr(readAddr),
        .writeLevel(writeLevel), .readLevel(readLevel),
        .anyClear(writeClear || readClear),
        .burstDone(burstDone), .burstStart(burstStart), .burstReq(burstReq)
    );

    sdramSequencer sequencer (
        .CLK(CLK), .RESET_N(RESET_N),
        .burstStart(burstStart), .burstReq(burstReq), .burstDone(burstDone),
        .writePop(writePop), .readPush(readPush), .sdramBus(sdramBus)
    );

endmodule

`default_nettype wire

// ==== sdramChipModel.sv ====
//==========================================================================
// Behavioural SDRAM for the testbench
// Opens a row on ACTIVE, runs page-mode bursts on READ or WRITE and
// returns read data after the CAS latency. Only the low 4K words exist
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module sdramChipModel (
    input  wire logic                         CLK,
    input  wire sdramPkg::sdramBusT           bus,
    input  wire logic [sdramPkg::dataW-1:0]   dqWrite,   // Controller data
    output logic      [sdramPkg::dataW-1:0]   dqRead     // Chip data
);
    import sdramPkg::*;

    logic [dataW-1:0] mem [4096];              // Aliases above 4K words
    logic [bankW-1:0] openBank;
    logic [rowW-1:0]  openRow;
    logic [colW-1:0]  writeCol;
    logic [colW-1:0]  readCol;
    logic             reading;
    logic [1:0]       readDelay;

    function automatic logic [11:0] memIndex(input logic [colW-1:0] col);
        logic [addrW-1:0] full;
        full = {openBank, openRow, col};
        return full[11:0];
    endfunction

    initial
    begin
        reading = 1'b0;
        dqRead  = '0;
    end

    always @(posedge CLK)
    begin
        if (!bus.csN && bus.cmd == ACTIVE)
        begin
            openBank <= bus.ba;
            openRow  <= bus.sa;
        end
        // Write data rides with the WRITE command and the cycles after it
        if (!bus.csN && bus.cmd == WRITE && bus.dqOe && bus.dqm == 2'b00)
        begin
            mem[memIndex(bus.sa[colW-1:0])] <= dqWrite;
            writeCol <= bus.sa[colW-1:0] + 1'b1;
        end
        else if (bus.dqOe && bus.dqm == 2'b00)
        begin
            mem[memIndex(writeCol)] <= dqWrite;
            writeCol <= writeCol + 1'b1;       // Wraps inside the page
        end
        // Read pipeline, first word visible casLatency cycles after READ
        if (!bus.csN && bus.cmd == READ)
        begin
            reading   <= 1'b1;
            readDelay <= 2'(casLatency - 2);
            readCol   <= bus.sa[colW-1:0];
        end
        else if (!bus.csN && bus.cmd == PRECHARGE)
            reading <= 1'b0;
        else if (reading)
        begin
            if (readDelay != 0)
                readDelay <= readDelay - 1'b1;
            else
            begin
                dqRead  <= mem[memIndex(readCol)];
                readCol <= readCol + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sdramMultiPort_properties.sv ====
//==========================================================================
// Concurrent checks on the burst sequencer, bound into sdramSequencer
// Command spacing, start to done distance and the DQ enable window
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module sdramMultiPort_properties (
    input  wire logic                          CLK,
    input  wire logic                          RESET_N,
    input  wire logic                          burstStart,
    input  wire logic                          burstDone,
    input  wire sdramPkg::sdramBusT            sdramBus,
    input  wire logic [portPkg::lengthW-1:0]   reqLength,   // Latched length
    input  wire logic                          reqIsWrite
);
    import sdramPkg::*;

    logic [7:0] sinceStart;                    // 0 on the ACTIVE cycle
    int         failCount = 0;                 // Assertion failures so far

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
            sinceStart <= '0;
        else if (burstStart)
            sinceStart <= '0;
        else
            sinceStart <= sinceStart + 1'b1;
    end

    rwAfterActive: assert property (@(posedge CLK) disable iff (!RESET_N)
        (!sdramBus.csN && sdramBus.cmd == ACTIVE) |->
            ##tRcd (sdramBus.cmd == READ || sdramBus.cmd == WRITE))
        else
        begin
            failCount++;
            $error("READ or WRITE not tRcd cycles after ACTIVE");
        end

    doneDistance: assert property (@(posedge CLK) disable iff (!RESET_N)
        burstDone |-> (sinceStart == 8'(tRcd + casLatency + 2) + 8'(reqLength)))
        else
        begin
            failCount++;
            $error("burstDone at the wrong cycle after burstStart");
        end

    // Write data cycles run from the WRITE command for reqLength cycles
    oeOnlyOnWrite: assert property (@(posedge CLK) disable iff (!RESET_N)
        sdramBus.dqOe |-> reqIsWrite && sdramBus.dqm == 2'b00 &&
            sinceStart >= 8'(tRcd) && sinceStart < 8'(tRcd) + 8'(reqLength))
        else
        begin
            failCount++;
            $error("DQ driven outside the write data cycles");
        end

endmodule

`default_nettype wire

// ==== tbSdramMultiPort.sv ====
//==========================================================================
// Testbench for the two-port SDRAM controller
// Phase 1 writes 96 random words round a wrapping ring, phase 2 reads
// 32 words back, phase 3 clears the read port and reads 16 more
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module tbSdramMultiPort;
    import sdramPkg::*;
    import portPkg::*;

    localparam logic [addrW-1:0] ringStart = 22'h000100;
    localparam logic [addrW-1:0] ringMax   = 22'h000140;
    localparam int burstLen  = 8;
    localparam int maxCycles = 4000;           // About 10x the expected run

    logic CLK = 1'b0;
    logic RESET_N;
    portCfgT writeCfg, readCfg;
    logic [dataW-1:0] writeData, readData, dqOut, dqIn, chipDq;
    logic writeEn, writeClear, readEn, readClear;
    logic [levelW-1:0] writeLevel, readLevel;
    sdramBusT sdramBus;

    integer seed = 17657;
    int errors = 0;
    int cycles = 0;
    int pushCount = 0;
    int writesSeen = 0;
    logic [dataW-1:0] pushed [$];
    logic [dataW-1:0] memModel [4096];         // Expected chip contents
    logic [addrW-1:0] refWriteAddr = ringStart;
    logic [rowW-1:0]  actRow;
    logic [bankW-1:0] actBank;

    always #4 CLK = ~CLK;                      // 8 ns period

    sdramMultiPort uut (
        .CLK(CLK), .RESET_N(RESET_N), .writeCfg(writeCfg), .readCfg(readCfg),
        .writeData(writeData), .writeEn(writeEn), .writeClear(writeClear),
        .readEn(readEn), .readClear(readClear), .readData(readData),
        .writeLevel(writeLevel), .readLevel(readLevel), .sdramBus(sdramBus),
        .dqOut(dqOut), .dqIn(dqIn)
    );

    sdramChipModel chip (.CLK(CLK), .bus(sdramBus), .dqWrite(dqOut), .dqRead(chipDq));

    assign dqIn = sdramBus.dqOe ? dqOut : chipDq; // Shared DQ resolved here

    bind sdramSequencer sdramMultiPort_properties props (
        .CLK(CLK), .RESET_N(RESET_N), .burstStart(burstStart),
        .burstDone(burstDone), .sdramBus(sdramBus),
        .reqLength(reqQ.length), .reqIsWrite(reqQ.isWrite)
    );

    // Reference ring step
    function automatic logic [addrW-1:0] ringNext(input logic [addrW-1:0] a);
        return (a < ringMax - addrW'(burstLen)) ? a + addrW'(burstLen) : ringStart;
    endfunction

    //======================================================================
    // Bus monitor for write addresses and burst gating
    //======================================================================
    always @(posedge CLK)
    begin
        logic [addrW-1:0] seenAddr;
        cycles++;
        if (cycles >= maxCycles)
        begin
            $display("Timeout: simulation ran past %0d cycles", maxCycles);
            $display("TESTS FAILED");
            $finish;
        end
        else if (RESET_N && !sdramBus.csN)
        begin
            if (sdramBus.cmd == ACTIVE)
            begin
                actRow  = sdramBus.sa;
                actBank = sdramBus.ba;
            end
            else if (sdramBus.cmd == WRITE)
            begin
                seenAddr = {actBank, actRow, sdramBus.sa[colW-1:0]};
                assert (seenAddr == refWriteAddr) else
                begin
                    errors++;
                    $display("[ERROR] %0t: WRITE at %h, expected %h",
                             $time, seenAddr, refWriteAddr);
                end
                assert (pushCount >= burstLen * (writesSeen + 1)) else
                begin
                    errors++;
                    $display("[ERROR] %0t: WRITE before a full burst was pushed", $time);
                end
                for (int i = 0; i < burstLen; i++)
                    memModel[refWriteAddr[11:0] + 12'(i)] = pushed[burstLen * writesSeen + i];
                writesSeen++;
                refWriteAddr = ringNext(refWriteAddr);
            end
        end
    end

    // Checks the head word and pops it when the FIFO is not empty
    task automatic popCheck(input logic [dataW-1:0] expected, output bit done);
        done = 1'b0;
        readEn = 1'b0;
        if (readLevel != 0)
        begin
            assert (readData == expected) else
            begin
                errors++;
                $display("[ERROR] %0t: read %h, expected %h", $time, readData, expected);
            end
            readEn = 1'b1;
            done = 1'b1;
        end
    endtask

    // Reads n words along the ring from its start
    task automatic readStream(input int n);
        logic [addrW-1:0] addr;
        int k;
        bit done;
        addr = ringStart;
        k = 0;
        while (k < n)
        begin
            @(posedge CLK);
            #1;
            popCheck(memModel[addr[11:0] + 12'(k % burstLen)], done);
            if (done)
            begin
                k++;
                if (k % burstLen == 0)
                    addr = ringNext(addr);
            end
        end
        @(posedge CLK);
        #1 readEn = 1'b0;
    endtask

    //======================================================================
    // Stimulus
    //======================================================================
    initial
    begin
        RESET_N = 1'b0;
        writeCfg = '{startAddr: ringStart, maxAddr: ringMax, length: 6'(burstLen)};
        readCfg  = '{startAddr: ringStart, maxAddr: ringMax, length: '0};
        writeData = '0;
        writeEn = 1'b0;
        writeClear = 1'b0;
        readEn = 1'b0;
        readClear = 1'b0;
        repeat (10) @(posedge CLK);
        #1 RESET_N = 1'b1;
        @(posedge CLK);
        #1;
        assert (sdramBus.csN && sdramBus.cmd == NOP && sdramBus.dqm == 2'b11
                && !sdramBus.dqOe) else
        begin
            errors++;
            $display("[ERROR] %0t: bus not idle after reset", $time);
        end

        // Phase 1 pushes 96 words over a wrapping write ring
        while (pushCount < 96)
        begin
            @(posedge CLK);
            #1;
            writeEn = 1'b0;
            if (writeLevel < 7'd64)
            begin
                writeData = 16'($random(seed));
                writeEn = 1'b1;
                pushed.push_back(writeData);
                pushCount++;
            end
        end
        @(posedge CLK);
        #1 writeEn = 1'b0;
        while (writesSeen < 12 || writeLevel != 0 || uut.arbiter.busy)
        begin
            @(posedge CLK);
            #1;
        end
        for (int a = 'h100; a < 'h140; a++)
            assert (chip.mem[a] == memModel[a]) else
            begin
                errors++;
                $display("[ERROR] %0t: chip word %h is %h, expected %h",
                         $time, a, chip.mem[a], memModel[a]);
            end

        // Phase 2 reads back along the same ring
        writeCfg.length = '0;
        readCfg.length = 6'(burstLen);
        readClear = 1'b1;
        @(posedge CLK);
        #1 readClear = 1'b0;
        readStream(32);

        // Phase 3 leaves one burst unread in the FIFO, then clears the port
        while (readLevel < 7'(burstLen) || uut.arbiter.busy)
        begin
            @(posedge CLK);
            #1;
        end
        readClear = 1'b1;
        @(posedge CLK);
        #1 readClear = 1'b0;
        assert (readLevel == 0) else
        begin
            errors++;
            $display("[ERROR] %0t: read level %0d after clear", $time, readLevel);
        end
        readStream(16);

        $display("Run finished with %0d check errors and %0d assertion failures",
                 errors, uut.sequencer.props.failCount);
        if (errors == 0 && uut.sequencer.props.failCount == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
sdramPkg.sv
portPkg.sv
burstFifo.sv
portAddressRing.sv
burstArbiter.sv
sdramSequencer.sv
sdramMultiPort.sv
sdramChipModel.sv
sdramMultiPort_properties.sv
tbSdramMultiPort.sv

// ==== Makefile ====
# Verilator build and run of the two-port SDRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tbSdramMultiPort
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
